// ==== rtl/rv_pkg.sv ====
package rv_pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		OP_LOAD   = 7'b0000011,
		OP_IMM    = 7'b0010011,
		OP_AUIPC  = 7'b0010111,
		OP_STORE  = 7'b0100011,
		OP_REG    = 7'b0110011,
		OP_LUI    = 7'b0110111,
		OP_BRANCH = 7'b1100011,
		OP_JALR   = 7'b1100111,
		OP_JAL    = 7'b1101111,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B	// LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		CLASS_ALU,
		CLASS_LOAD,
		CLASS_STORE,
		CLASS_BRANCH,
		CLASS_JAL,
		CLASS_JALR,
		CLASS_HALT,
		CLASS_ILLEGAL
	} inst_class_e;

	typedef struct packed {
		inst_class_e inst_class;
		alu_op_e     alu_op;
		logic [2:0]  funct3;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [31:0] imm;		// Sign-extended
		logic        use_imm;	// Operand b from imm instead of rs2
		logic        use_pc;	// Operand a from pc instead of rs1
	} decoded_t;

	typedef struct packed {
		logic        rw;		// 1 for write
		logic [31:0] address;
		logic [31:0] wdata;
	} bus_req_t;

endpackage

// ==== rtl/rv_decoder.sv ====
`timescale 1ns/10ps

module rv_decoder import rv_pkg::*; (
	input  logic [31:0] i_instruction,
	output decoded_t    o_decoded
);
	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign funct3 = i_instruction[14:12];
	assign funct7 = i_instruction[31:25];

	assign imm_i = {{21{i_instruction[31]}}, i_instruction[30:20]};
	assign imm_s = {{21{i_instruction[31]}}, i_instruction[30:25], i_instruction[11:7]};
	assign imm_b = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
		i_instruction[11:8], 1'b0};
	assign imm_u = {i_instruction[31:12], 12'b0};
	assign imm_j = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
		i_instruction[30:21], 1'b0};

	// Shared funct3 map of OP and OP-IMM
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	always_comb begin
		o_decoded = '0;
		o_decoded.inst_class = CLASS_ILLEGAL;
		o_decoded.alu_op = ALU_ADD;
		o_decoded.funct3 = funct3;
		o_decoded.rs1 = i_instruction[19:15];
		o_decoded.rs2 = i_instruction[24:20];
		o_decoded.rd = i_instruction[11:7];
		o_decoded.imm = imm_i;
		case (opcode_e'(i_instruction[6:0]))
			OP_LUI: begin
				o_decoded.inst_class = CLASS_ALU;
				o_decoded.alu_op = ALU_PASS_B;
				o_decoded.imm = imm_u;
				o_decoded.use_imm = 1'b1;
			end
			OP_AUIPC: begin
				o_decoded.inst_class = CLASS_ALU;
				o_decoded.imm = imm_u;
				o_decoded.use_imm = 1'b1;
				o_decoded.use_pc = 1'b1;
			end
			OP_JAL: begin
				o_decoded.inst_class = CLASS_JAL;
				o_decoded.imm = imm_j;
				o_decoded.use_imm = 1'b1;
				o_decoded.use_pc = 1'b1;	// Target computed by ALU
			end
			OP_JALR: begin
				o_decoded.use_imm = 1'b1;
				if (funct3 == 3'b000) o_decoded.inst_class = CLASS_JALR;
			end
			OP_BRANCH: begin
				o_decoded.imm = imm_b;
				if (funct3[2:1] != 2'b01) o_decoded.inst_class = CLASS_BRANCH;
			end
			OP_LOAD: begin
				o_decoded.use_imm = 1'b1;
				if (funct3 == 3'b010) o_decoded.inst_class = CLASS_LOAD;	// LW only
			end
			OP_STORE: begin
				o_decoded.imm = imm_s;
				o_decoded.use_imm = 1'b1;
				if (funct3 == 3'b010) o_decoded.inst_class = CLASS_STORE;	// SW only
			end
			OP_IMM: begin
				o_decoded.alu_op = arith_op(funct3, i_instruction[30] && funct3 == 3'b101);
				o_decoded.use_imm = 1'b1;
				if (funct3[1:0] != 2'b01 || funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && funct3 == 3'b101))
					o_decoded.inst_class = CLASS_ALU;
			end
			OP_REG: begin
				o_decoded.alu_op = arith_op(funct3, i_instruction[30]);
				if (funct7 == 7'b0000000 ||
						(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))
					o_decoded.inst_class = CLASS_ALU;
			end
			OP_SYSTEM: begin
				if (i_instruction == EBREAK_WORD) o_decoded.inst_class = CLASS_HALT;
			end
			default: ;	// Stays illegal
		endcase
	end

endmodule

// ==== rtl/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile #(
	parameter logic [31:0] STACK_INIT = 32'h0001_0400
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [4:0]  i_rs1_index,
	input  logic [4:0]  i_rs2_index,
	output logic [31:0] o_rs1_value,
	output logic [31:0] o_rs2_value,
	input  logic        i_write_enable,
	input  logic [4:0]  i_rd_index,
	input  logic [31:0] i_rd_value
);
	logic [31:0] regs [1:31];	// No storage behind x0

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			regs[2] <= STACK_INIT;	// sp
		end else if (i_write_enable && i_rd_index != 5'd0) begin
			regs[i_rd_index] <= i_rd_value;
		end
	end

	assign o_rs1_value = (i_rs1_index == 5'd0) ? 32'd0 : regs[i_rs1_index];
	assign o_rs2_value = (i_rs2_index == 5'd0) ? 32'd0 : regs[i_rs2_index];

	// The value being written was computed from these reads
	a_read_index_known: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_write_enable |-> !$isunknown({i_rs1_index, i_rs2_index})
	);

endmodule

// ==== rtl/rv_alu.sv ====
`timescale 1ns/10ps

module rv_alu import rv_pkg::*; (
	input  alu_op_e     i_op,
	input  logic [31:0] i_a,
	input  logic [31:0] i_b,
	input  logic [2:0]  i_funct3,
	output logic [31:0] o_result,
	output logic        o_branch_taken
);
	logic [4:0] shamt;
	logic lt_signed, lt_unsigned;

	assign shamt = i_b[4:0];
	assign lt_signed = $signed(i_a) < $signed(i_b);
	assign lt_unsigned = i_a < i_b;

	always_comb begin
		case (i_op)
			ALU_ADD:    o_result = i_a + i_b;
			ALU_SUB:    o_result = i_a - i_b;
			ALU_SLL:    o_result = i_a << shamt;
			ALU_SLT:    o_result = {31'd0, lt_signed};
			ALU_SLTU:   o_result = {31'd0, lt_unsigned};
			ALU_XOR:    o_result = i_a ^ i_b;
			ALU_SRL:    o_result = i_a >> shamt;
			ALU_SRA:    o_result = $unsigned($signed(i_a) >>> shamt);
			ALU_OR:     o_result = i_a | i_b;
			ALU_AND:    o_result = i_a & i_b;
			ALU_PASS_B: o_result = i_b;
			default:    o_result = 32'd0;
		endcase
	end

	// Branch compare on rs1/rs2
	always_comb begin
		case (i_funct3)
			3'b000:  o_branch_taken = i_a == i_b;	// beq
			3'b001:  o_branch_taken = i_a != i_b;	// bne
			3'b100:  o_branch_taken = lt_signed;	// blt
			3'b101:  o_branch_taken = !lt_signed;	// bge
			3'b110:  o_branch_taken = lt_unsigned;
			3'b111:  o_branch_taken = !lt_unsigned;
			default: o_branch_taken = 1'b0;
		endcase
	end

endmodule

// ==== rtl/rv_control.sv ====
`timescale 1ns/10ps

module rv_control import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_ready,
	input  logic [31:0] i_data,
	output logic        o_request,
	output bus_req_t    o_bus,
	output logic [31:0] o_pc,
	output logic        o_halted,
	output logic        o_error,
	output logic [31:0] o_instruction,
	input  decoded_t    i_decoded,
	input  logic [31:0] i_rs1_value,
	input  logic [31:0] i_rs2_value,
	output logic [31:0] o_alu_a,
	output logic [31:0] o_alu_b,
	output alu_op_e     o_alu_op,
	input  logic [31:0] i_alu_result,
	input  logic        i_branch_taken,
	output logic        o_rd_write,
	output logic [4:0]  o_rd_index,
	output logic [31:0] o_rd_value
);
	typedef enum logic [2:0] {
		ST_FETCH_WAIT,
		ST_EXECUTE,
		ST_MEM_WAIT,
		ST_RETIRE,
		ST_STOPPED
	} state_e;

	state_e state;
	logic [31:0] pc, pc_next, next_pc, pc_plus4;
	logic [31:0] instruction;

	assign o_pc = pc;
	assign o_instruction = instruction;
	assign pc_plus4 = pc + 32'd4;

	assign o_alu_a = i_decoded.use_pc ? pc : i_rs1_value;
	assign o_alu_b = i_decoded.use_imm ? i_decoded.imm : i_rs2_value;
	assign o_alu_op = i_decoded.alu_op;

	always_comb begin
		case (i_decoded.inst_class)
			CLASS_BRANCH: next_pc = i_branch_taken ? pc + i_decoded.imm : pc_plus4;
			CLASS_JAL:    next_pc = i_alu_result;
			CLASS_JALR:   next_pc = {i_alu_result[31:1], 1'b0};
			default:      next_pc = pc_plus4;
		endcase
	end

	// Register write from execute, or load data on its ready edge
	always_comb begin
		o_rd_index = i_decoded.rd;
		o_rd_write = 1'b0;
		o_rd_value = i_alu_result;
		if (state == ST_EXECUTE) begin
			case (i_decoded.inst_class)
				CLASS_ALU: o_rd_write = 1'b1;
				CLASS_JAL, CLASS_JALR: begin
					o_rd_write = 1'b1;
					o_rd_value = pc_plus4;	// Link
				end
				default: ;
			endcase
		end else if (state == ST_MEM_WAIT && i_ready && !o_bus.rw) begin
			o_rd_write = 1'b1;
			o_rd_value = i_data;
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_FETCH_WAIT && i_ready) instruction <= i_data;
	end

	always_ff @(posedge i_clock or posedge i_reset) begin
		if (i_reset) begin
			state <= ST_RETIRE;	// Retire issues the first fetch
			pc <= RESET_PC;
			pc_next <= RESET_PC;
			o_request <= 1'b0;
			o_bus <= '0;
			o_halted <= 1'b0;
			o_error <= 1'b0;
		end else begin
			case (state)
				ST_FETCH_WAIT: if (i_ready) begin
					o_request <= 1'b0;
					state <= ST_EXECUTE;
				end
				ST_EXECUTE: begin
					pc_next <= next_pc;
					case (i_decoded.inst_class)
						CLASS_LOAD, CLASS_STORE: begin
							o_bus.rw <= (i_decoded.inst_class == CLASS_STORE);
							o_bus.address <= i_alu_result;	// rs1 + imm
							o_bus.wdata <= i_rs2_value;
							o_request <= 1'b1;
							state <= ST_MEM_WAIT;
						end
						CLASS_HALT: begin
							o_halted <= 1'b1;
							state <= ST_STOPPED;
						end
						CLASS_ILLEGAL: begin
							o_error <= 1'b1;
							state <= ST_STOPPED;
						end
						default: state <= ST_RETIRE;
					endcase
				end
				ST_MEM_WAIT: if (i_ready) begin
					o_request <= 1'b0;
					state <= ST_RETIRE;
				end
				ST_RETIRE: begin
					o_bus <= '{rw: 1'b0, address: pc_next, wdata: 32'd0};
					o_request <= 1'b1;
					pc <= pc_next;
					state <= ST_FETCH_WAIT;
				end
				default: ;	// Stopped until reset
			endcase
		end
	end

	a_bus_held: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_request && !i_ready) |=> (o_request && $stable(o_bus))
	);

	a_quiet_when_stopped: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_halted || o_error) |-> !o_request
	);

endmodule

// ==== rtl/rv_cpu.sv ====
`timescale 1ns/10ps

module rv_cpu import rv_pkg::*; #(
	parameter logic [31:0] RESET_PC   = 32'h0000_0000,
	parameter logic [31:0] STACK_INIT = 32'h0001_0400
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_ready,
	input  logic [31:0] i_data,
	output logic        o_request,
	output bus_req_t    o_bus,
	output logic [31:0] o_pc,
	output logic        o_halted,
	output logic        o_error
);
	logic [31:0] instruction;
	decoded_t decoded;
	logic [31:0] rs1_value, rs2_value;
	logic [31:0] alu_a, alu_b, alu_result;
	alu_op_e alu_op;
	logic branch_taken;
	logic rd_write;
	logic [4:0] rd_index;
	logic [31:0] rd_value;

	rv_control #(.RESET_PC(RESET_PC)) rv_control_inst (
		.i_clock, .i_reset, .i_ready, .i_data,
		.o_request, .o_bus, .o_pc, .o_halted, .o_error,
		.o_instruction(instruction),
		.i_decoded(decoded),
		.i_rs1_value(rs1_value),
		.i_rs2_value(rs2_value),
		.o_alu_a(alu_a),
		.o_alu_b(alu_b),
		.o_alu_op(alu_op),
		.i_alu_result(alu_result),
		.i_branch_taken(branch_taken),
		.o_rd_write(rd_write),
		.o_rd_index(rd_index),
		.o_rd_value(rd_value)
	);

	rv_decoder rv_decoder_inst (
		.i_instruction(instruction),
		.o_decoded(decoded)
	);

	rv_regfile #(.STACK_INIT(STACK_INIT)) rv_regfile_inst (
		.i_clock, .i_reset,
		.i_rs1_index(decoded.rs1),
		.i_rs2_index(decoded.rs2),
		.o_rs1_value(rs1_value),
		.o_rs2_value(rs2_value),
		.i_write_enable(rd_write),
		.i_rd_index(rd_index),
		.i_rd_value(rd_value)
	);

	rv_alu rv_alu_inst (
		.i_op(alu_op),
		.i_a(alu_a),
		.i_b(alu_b),
		.i_funct3(decoded.funct3),	// Branch condition
		.o_result(alu_result),
		.o_branch_taken(branch_taken)
	);

endmodule

// ==== tests/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam int PROGRAM_WORDS = 49;
localparam int STORE_COUNT = 13;
localparam int PASS_COUNT = 3;
localparam int MAX_LATENCY = 3;		// Largest ready delay of any pass
localparam logic [31:0] EBREAK = 32'h0010_0073;
localparam logic [31:0] BAD_WORD = 32'hFFFF_FFFF;	// Opcode 1111111 is not RV32I

typedef struct packed {
	logic [1:0]  max_latency;	// Ready delay drawn from 0 up to this
	logic [31:0] stop_word;		// Replaces the last program word
	logic        expect_error;
	logic [4:0]  reset_after;	// Stores seen before a mid-run reset, 0 for none
} pass_t;

localparam pass_t PASSES [PASS_COUNT] = '{
	'{2'd0, EBREAK, 1'b0, 5'd0},
	'{2'd3, EBREAK, 1'b0, 5'd5},
	'{2'd2, BAD_WORD, 1'b1, 5'd0}
};

// Every store the program makes, in order
localparam bus_req_t EXPECTED_STORES [STORE_COUNT] = '{
	'{1'b1, 32'h0000_0100, 32'h1234_5678},	// lui + addi
	'{1'b1, 32'h0000_0104, 32'h0000_100C},	// auipc at pc 0xC
	'{1'b1, 32'h0000_0108, 32'hFFFF_FFFC},	// -16 sra 2
	'{1'b1, 32'h0000_010C, 32'h0FFF_FFFF},	// -16 srl 4
	'{1'b1, 32'h0000_0110, 32'h0000_0002},	// (sltu | slt << 1)
	'{1'b1, 32'h0000_0114, 32'hEFFF_FFFF},
	'{1'b1, 32'h0000_0118, 32'h0000_00F0},
	'{1'b1, 32'h0000_011C, 32'h0000_0068},	// jal link
	'{1'b1, 32'h0000_0120, 32'h0000_007C},	// jalr link
	'{1'b1, 32'h0000_0180, 32'hCAFE_AABE},
	'{1'b1, 32'h0000_0124, 32'hCAFE_AABE},	// Loaded back
	'{1'b1, STACK_INIT - 32'd8, 32'hCAFE_AABE},	// sp - 8
	'{1'b1, 32'h0000_0128, 32'hCAFE_AABF}
};

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

// SW only
function automatic logic [31:0] enc_s(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
endfunction

function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

function automatic logic [31:0] program_word(input int index);
	case (index)
		0:  return enc_u(OP_LUI, 5'd5, 20'h12345);
		1:  return enc_i(OP_IMM, 3'b000, 5'd5, 5'd5, 12'h678);
		2:  return enc_s(5'd0, 5'd5, 12'h100);
		3:  return enc_u(OP_AUIPC, 5'd6, 20'h00001);
		4:  return enc_s(5'd0, 5'd6, 12'h104);
		5:  return enc_i(OP_IMM, 3'b000, 5'd7, 5'd0, 12'hFF0);	// x7 = -16
		6:  return enc_i(OP_IMM, 3'b101, 5'd8, 5'd7, 12'h402);	// srai
		7:  return enc_i(OP_IMM, 3'b101, 5'd9, 5'd7, 12'h004);	// srli
		8:  return enc_r(7'h00, 3'b011, 5'd10, 5'd7, 5'd5);	// sltu gives 0
		9:  return enc_r(7'h00, 3'b010, 5'd11, 5'd7, 5'd5);	// slt gives 1
		10: return enc_i(OP_IMM, 3'b001, 5'd11, 5'd11, 12'h001);
		11: return enc_r(7'h00, 3'b110, 5'd10, 5'd10, 5'd11);
		12: return enc_r(7'h20, 3'b000, 5'd12, 5'd9, 5'd5);	// sub
		13: return enc_r(7'h00, 3'b100, 5'd13, 5'd12, 5'd5);
		14: return enc_i(OP_IMM, 3'b111, 5'd14, 5'd13, 12'h0F0);
		15: return enc_s(5'd0, 5'd8, 12'h108);
		16: return enc_s(5'd0, 5'd9, 12'h10C);
		17: return enc_s(5'd0, 5'd10, 12'h110);
		18: return enc_s(5'd0, 5'd13, 12'h114);
		19: return enc_s(5'd0, 5'd14, 12'h118);
		20: return enc_b(3'b000, 5'd10, 5'd11, 13'd8);	// beq taken
		21: return enc_s(5'd0, 5'd0, 12'h1F0);
		22: return enc_b(3'b110, 5'd7, 5'd5, 13'd8);	// bltu not taken
		23: return enc_b(3'b100, 5'd7, 5'd5, 13'd8);	// blt taken
		24: return enc_s(5'd0, 5'd0, 12'h1F4);
		25: return enc_j(5'd1, 21'd12);
		26: return enc_s(5'd0, 5'd0, 12'h1F8);
		27: return enc_s(5'd0, 5'd0, 12'h1FC);
		28: return enc_s(5'd0, 5'd1, 12'h11C);
		29: return enc_i(OP_IMM, 3'b000, 5'd15, 5'd0, 12'd129);
		30: return enc_i(OP_JALR, 3'b000, 5'd3, 5'd15, 12'd8);	// 137 lands on 136
		31: return enc_s(5'd0, 5'd0, 12'h1F0);
		32: return enc_s(5'd0, 5'd0, 12'h1F4);
		33: return enc_s(5'd0, 5'd0, 12'h1F8);
		34: return enc_s(5'd0, 5'd3, 12'h120);
		35: return enc_b(3'b001, 5'd3, 5'd3, 13'd8);	// bne not taken
		36: return enc_b(3'b101, 5'd7, 5'd5, 13'd8);	// bge not taken
		37: return enc_b(3'b111, 5'd7, 5'd5, 13'd8);	// bgeu taken
		38: return enc_s(5'd0, 5'd0, 12'h1FC);
		39: return enc_u(OP_LUI, 5'd16, 20'hCAFEB);
		40: return enc_i(OP_IMM, 3'b000, 5'd16, 5'd16, 12'hABE);	// -0x542
		41: return enc_s(5'd0, 5'd16, 12'h180);
		42: return enc_i(OP_LOAD, 3'b010, 5'd17, 5'd0, 12'h180);
		43: return enc_s(5'd0, 5'd17, 12'h124);
		44: return enc_s(5'd2, 5'd17, 12'hFF8);
		45: return enc_i(OP_LOAD, 3'b010, 5'd18, 5'd2, 12'hFF8);
		46: return enc_i(OP_IMM, 3'b000, 5'd18, 5'd18, 12'h001);
		47: return enc_s(5'd0, 5'd18, 12'h128);
		default: return EBREAK;
	endcase
endfunction

`endif

// ==== tests/tb_rv_cpu.sv ====
`timescale 1ns/10ps

module tb_rv_cpu import rv_pkg::*; ();
	localparam logic [31:0] RESET_PC = 32'h0000_0000;
	localparam logic [31:0] STACK_INIT = 32'h0000_8000;
	localparam int RESET_CYCLES = 16;
	localparam int QUIET_CYCLES = 20;	// Idle check after a stop
	localparam int RANDOM_SEED = 85262;

	`include "tb_program.svh"

	// Per program word 40 cycles for each step of latency, plus resets
	localparam int WATCHDOG_CYCLES = PASS_COUNT * PROGRAM_WORDS * 40 * MAX_LATENCY + 2000;

	logic        i_clock;
	logic        i_reset;
	logic        i_ready;
	logic [31:0] i_data;
	logic        o_request;
	bus_req_t    o_bus;
	logic [31:0] o_pc;
	logic        o_halted;
	logic        o_error;

	logic [31:0] memory [logic [29:0]];	// Keyed by word address
	bus_req_t store_q [$];
	int max_latency = 0;

	rv_cpu #(.RESET_PC(RESET_PC), .STACK_INIT(STACK_INIT)) rv_cpu_inst (
		.i_clock, .i_reset, .i_ready, .i_data,
		.o_request, .o_bus, .o_pc, .o_halted, .o_error
	);

	always #10 i_clock = ~i_clock;

	task automatic report_failure(input string message);
		$display("%s", message);
		$display("SOME TESTS FAILED");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic check_store(input string name, input bus_req_t expected,
			input bus_req_t actual);
		if (actual !== expected)
			report_failure($sformatf(
				"Mismatch at %0t: %s expected rw=%b addr=%h data=%h got rw=%b addr=%h data=%h",
				$time, name, expected.rw, expected.address, expected.wdata,
				actual.rw, actual.address, actual.wdata));
	endtask

	task automatic check_address(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch at %0t: %s expected %h got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_request(input logic expected);
		if (o_request !== expected)
			report_failure($sformatf("Mismatch at %0t: o_request expected %b got %b",
				$time, expected, o_request));
	endtask

	task automatic check_flags(input logic exp_halted, input logic exp_error);
		if (o_halted !== exp_halted)
			report_failure($sformatf("Mismatch at %0t: o_halted expected %b got %b",
				$time, exp_halted, o_halted));
		if (o_error !== exp_error)
			report_failure($sformatf("Mismatch at %0t: o_error expected %b got %b",
				$time, exp_error, o_error));
	endtask

	function automatic logic [31:0] read_word(input logic [31:0] address);
		if (memory.exists(address[31:2]))
			return memory[address[31:2]];
		return address ^ 32'hDEAD_BEEF;	// Unwritten words
	endfunction

	// Reloads the program and resets the core, then sees the first fetch
	task automatic start_run(input logic [31:0] stop_word);
		@(negedge i_clock);
		i_reset = 1'b1;
		memory.delete();
		for (int i = 0; i < PROGRAM_WORDS; i++)
			memory[30'(i)] = program_word(i);
		memory[30'(PROGRAM_WORDS - 1)] = stop_word;
		store_q.delete();
		repeat (RESET_CYCLES) begin
			@(negedge i_clock);
			check_request(1'b0);
			check_flags(1'b0, 1'b0);
		end
		i_reset = 1'b0;
		@(negedge i_clock);
		check_request(1'b1);	// Rises on the first edge after release
		check_store("o_bus", '{1'b0, RESET_PC, 32'd0}, o_bus);
		check_address("o_pc", RESET_PC, o_pc);
	endtask

	task automatic take_store(input int index, output bus_req_t store);
		while (store_q.size() == 0) begin
			if (o_halted || o_error)
				report_failure($sformatf("Core stopped at pc %h before store %0d arrived",
					o_pc, index));
			else
				@(negedge i_clock);
		end
		store = store_q.pop_front();
	endtask

	task automatic wait_for_stop(input logic expect_error);
		while (!o_halted && !o_error)
			@(negedge i_clock);
		check_flags(!expect_error, expect_error);
		repeat (QUIET_CYCLES) begin
			@(negedge i_clock);
			check_request(1'b0);
		end
		if (store_q.size() != 0)
			report_failure($sformatf("Unexpected store to %h after the last expected one",
				store_q[0].address));
	endtask

	// Memory model, answers after 0 to max_latency cycles
	initial begin
		int delay_left;
		logic hold_valid;
		bus_req_t held_bus;
		bus_req_t served;
		i_ready = 1'b0;
		i_data = 32'd0;
		delay_left = -1;
		hold_valid = 1'b0;
		held_bus = '0;
		served = '0;
		void'($urandom(RANDOM_SEED));
		forever begin
			@(negedge i_clock);
			if (hold_valid && !i_reset) begin	// Waited through the last edge
				check_request(1'b1);
				check_store("o_bus", held_bus, o_bus);
			end
			if (i_reset) begin
				i_ready = 1'b0;
				delay_left = -1;
			end else if (i_ready) begin
				// Transfer done on the edge just passed
				if (served.rw) begin
					memory[served.address[31:2]] = served.wdata;
					store_q.push_back(served);
				end
				i_ready = 1'b0;
				delay_left = -1;
			end else if (o_request) begin
				if (delay_left < 0)
					delay_left = $urandom_range(max_latency, 0);
				if (delay_left == 0) begin
					served = o_bus;
					i_data = served.rw ? 32'd0 : read_word(served.address);
					i_ready = 1'b1;
				end else begin
					delay_left--;
				end
			end
			hold_valid = !i_reset && o_request && !i_ready;
			held_bus = o_bus;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		report_failure($sformatf("Timeout after %0d cycles without finishing", WATCHDOG_CYCLES));
	end

	initial begin
		bus_req_t actual;
		pass_t pass_cfg;
		logic reset_done;
		int count;
		i_clock = 1'b0;
		i_reset = 1'b1;
		for (int p = 0; p < PASS_COUNT; p++) begin
			pass_cfg = PASSES[p];
			max_latency = pass_cfg.max_latency;
			reset_done = 1'b0;
			start_run(pass_cfg.stop_word);
			count = 0;
			while (count < STORE_COUNT) begin
				take_store(count, actual);
				check_store("o_bus", EXPECTED_STORES[count], actual);
				count++;
				if (!reset_done && count == pass_cfg.reset_after) begin
					start_run(pass_cfg.stop_word);	// Program starts over
					reset_done = 1'b1;
					count = 0;
				end
			end
			wait_for_stop(pass_cfg.expect_error);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+tests
rtl/rv_pkg.sv
rtl/rv_decoder.sv
rtl/rv_regfile.sv
rtl/rv_alu.sv
rtl/rv_control.sv
rtl/rv_cpu.sv
tests/tb_rv_cpu.sv

// ==== Bender.yml ====
package:
  name: rv_cpu

sources:
  - rtl/rv_pkg.sv
  - rtl/rv_decoder.sv
  - rtl/rv_regfile.sv
  - rtl/rv_alu.sv
  - rtl/rv_control.sv
  - rtl/rv_cpu.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_rv_cpu.sv
